/* sources.f */
+incdir+tests
common/uart_pkg.sv
rx/uart_rx.sv
tx/uart_tx.sv
hdl/cmd_decoder.sv
hdl/bus_regs.sv
hdl/uart_bridge.sv
tests/tb_uart_bridge.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_uart_bridge
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?=

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := tests/tb_uart_bridge_tasks.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_uart_bridge_tasks.svh */
`ifndef TB_UART_BRIDGE_TASKS_SVH
`define TB_UART_BRIDGE_TASKS_SVH

// Reference model state
logic      mdl_user_rst;
logic      mdl_com_mode;
int        mdl_left;      // Memory write bytes still to come
mem_addr_t mdl_addr;
bus_data_t mdl_data;
byte_t     mdl_rx_rec;
logic      mdl_rx_full;
bus_addr_t exp_mem_addr[$];
bus_data_t exp_mem_data[$];
byte_t     exp_tx[$];

task automatic end_with_failure();
   $display("Result: FAILED");
   $fatal(1, "simulation stopped at %0t", $time);
endtask

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
   if (got !== exp) begin
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
      end_with_failure();
   end
endtask

// Command decoding as seen from the serial side
task automatic model_byte(input byte_t b);
   if (mdl_com_mode) begin
      mdl_rx_rec  = b;
      mdl_rx_full = 1'b1;
   end else if (mdl_left > 4) begin
      mdl_addr = {b, mdl_addr[15:8]};   // LSB arrives first
      mdl_left--;
   end else if (mdl_left > 0) begin
      mdl_data = {b, mdl_data[31:8]};
      mdl_left--;
      if (mdl_left == 0) begin
         exp_mem_addr.push_back(bus_addr_t'(mdl_addr));
         exp_mem_data.push_back(mdl_data);
      end
   end else begin
      case (b)
         CMD_PROG_MEM: mdl_left = 6;
         CMD_RST_CLR:  mdl_user_rst = 1'b0;
         CMD_RST_SET:  mdl_user_rst = 1'b1;
         CMD_COM_MODE: mdl_com_mode = 1'b1;
         default: begin
         end
      endcase
   end
endtask

// One 8N1 frame on uart_rx
task automatic send_byte(input byte_t b);
   logic [9:0] frame;
   int         rx_before;
   frame     = {1'b1, b, 1'b0};
   rx_before = rx_count;
   model_byte(b);
   for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      uart_rx = frame[i];
      repeat (CLKS_PER_BIT - 1) @(negedge clk);
   end
   check("rx_valid count", rx_count, rx_before + 1);
endtask

task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
   @(negedge clk);
   bus_wr_valid = 1'b1;
   bus_wr_addr  = addr;
   bus_wr_data  = data;
   @(negedge clk);
   bus_wr_valid = 1'b0;
endtask

task automatic bus_read(input bus_addr_t addr, output logic ready, output bus_data_t data);
   @(negedge clk);
   bus_rd_valid = 1'b1;
   bus_rd_addr  = addr;
   @(posedge clk);   // Answer settled for half a cycle
   ready = bus_rd_ready;
   data  = bus_rd_data;
   @(negedge clk);
   bus_rd_valid = 1'b0;
endtask

task automatic read_check(input bus_addr_t addr, input string name, input logic exp_ready,
                          input bus_data_t exp_data);
   logic      ready;
   bus_data_t data;
   bus_read(addr, ready, data);
   check({name, " ready"}, ready, exp_ready);
   check(name, data, exp_data);
endtask

`endif

/* tests/tb_uart_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_bridge;
   import uart_pkg::*;

   localparam int    N_MEM       = 4;
   localparam int    N_NOISE     = 6;   // Non-command bytes in the user reset test
   localparam int    N_TX        = 3;
   localparam int    N_COM       = 6;
   localparam int    NUM_FRAMES  = N_MEM * 7 + N_NOISE + 2 + N_TX + N_COM + 9;
   localparam int    WATCHDOG_NS = NUM_FRAMES * 10 * CLKS_PER_BIT * 10 * 2;

   logic      clk;
   logic      c_ex_rst;
   logic      uart_rx;
   logic      uart_tx;
   logic      c_user_rst;
   logic      bus_wr_valid;
   bus_addr_t bus_wr_addr;
   bus_data_t bus_wr_data;
   logic      bus_rd_valid;
   bus_addr_t bus_rd_addr;
   logic      bus_rd_ready;
   bus_data_t bus_rd_data;
   logic      mem_wr_valid;
   bus_addr_t mem_wr_addr;
   bus_data_t mem_wr_data;
   integer    seed = 32'h156f;
   int        rx_count = 0;
   int        tx_frames = 0;
   logic      rd_ready;
   bus_data_t rd_data;

   `include "tb_uart_bridge_tasks.svh"

   uart_bridge dut0 (
      .clk          (clk),
      .c_ex_rst     (c_ex_rst),
      .uart_rx      (uart_rx),
      .uart_tx      (uart_tx),
      .c_user_rst   (c_user_rst),
      .bus_wr_valid (bus_wr_valid),
      .bus_wr_addr  (bus_wr_addr),
      .bus_wr_data  (bus_wr_data),
      .bus_rd_valid (bus_rd_valid),
      .bus_rd_addr  (bus_rd_addr),
      .bus_rd_ready (bus_rd_ready),
      .bus_rd_data  (bus_rd_data),
      .mem_wr_valid (mem_wr_valid),
      .mem_wr_addr  (mem_wr_addr),
      .mem_wr_data  (mem_wr_data)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
      end_with_failure();
   end

   always @(negedge clk) begin
      if (dut0.rx_valid === 1'b1) rx_count++;
   end

   always @(negedge clk) begin
      if (mem_wr_valid === 1'b1) begin
         if (exp_mem_addr.size() == 0) begin
            $display("Memory write strobe without a complete write command");
            end_with_failure();
         end else begin
            check("mem_wr_addr", mem_wr_addr, exp_mem_addr.pop_front());
            check("mem_wr_data", mem_wr_data, exp_mem_data.pop_front());
         end
      end
   end

   // Decodes uart_tx at the middle of each bit
   initial begin
      byte_t got;
      @(negedge c_ex_rst);
      forever begin
         @(negedge uart_tx);
         if (exp_tx.size() == 0) begin
            $display("Frame on uart_tx that no bus write started");
            end_with_failure();
         end else begin
            repeat (CLKS_HALF_BIT) @(negedge clk);
            check("uart_tx start bit", uart_tx, 1'b0);
            for (int i = 0; i < 8; i++) begin
               repeat (CLKS_PER_BIT) @(negedge clk);
               got[i] = uart_tx;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            check("uart_tx stop bit", uart_tx, 1'b1);
            check("uart_tx byte", got, exp_tx.pop_front());
            tx_frames++;
         end
      end
   end

   function automatic byte_t random_non_cmd();
      byte_t r;
      r = byte_t'($random(seed));
      while (r == CMD_PROG_MEM || r == CMD_RST_CLR || r == CMD_RST_SET ||
             r == CMD_COM_MODE) begin
         r = byte_t'($random(seed));
      end
      return r;
   endfunction

   task automatic wait_tx_frame(input int n);
      int waited;
      waited = 0;
      while (tx_frames < n && waited < 11 * CLKS_PER_BIT) begin
         @(negedge clk);
         waited++;
      end
      if (tx_frames < n) begin
         $display("No complete frame seen on uart_tx after a transmit write");
         end_with_failure();
      end
   endtask

   task automatic wait_tx_idle();
      int        waited;
      logic      ready;
      bus_data_t data;
      waited = 0;
      bus_read(TX_BUSY_ADDR, ready, data);
      while (data != 0 && waited < CLKS_PER_BIT) begin
         bus_read(TX_BUSY_ADDR, ready, data);
         waited++;
      end
      check("tx_busy after frame", data, 0);
   endtask

   initial begin
      byte_t     b;
      bus_addr_t a;
      bus_data_t d;
      c_ex_rst     = 1'b1;
      uart_rx      = 1'b1;
      bus_wr_valid = 1'b0;
      bus_wr_addr  = '0;
      bus_wr_data  = '0;
      bus_rd_valid = 1'b0;
      bus_rd_addr  = '0;
      mdl_user_rst = 1'b1;
      mdl_com_mode = 1'b0;
      mdl_left     = 0;
      mdl_addr     = '0;
      mdl_data     = '0;
      mdl_rx_rec   = '0;
      mdl_rx_full  = 1'b0;
      @(posedge clk);
      repeat (2) @(negedge clk);
      c_ex_rst = 1'b0;

      check("uart_tx", uart_tx, 1'b1);
      check("c_user_rst", c_user_rst, 1'b1);
      check("mem_wr_valid", mem_wr_valid, 1'b0);
      read_check(RX_FULL_ADDR, "rx_full", 1'b1, 0);
      read_check(TX_BUSY_ADDR, "tx_busy", 1'b1, 0);

      repeat (N_MEM) begin
         a = $random(seed);
         d = $random(seed);
         send_byte(CMD_PROG_MEM);
         send_byte(a[7:0]);
         send_byte(a[15:8]);
         for (int i = 0; i < 4; i++) send_byte(d[8*i +: 8]);
         check("pending memory writes", exp_mem_addr.size(), 0);
      end

      for (int i = 0; i < N_NOISE + 2; i++) begin
         if (i == N_NOISE / 2) b = CMD_RST_CLR;
         else if (i == N_NOISE + 1) b = CMD_RST_SET;
         else b = random_non_cmd();
         send_byte(b);
         check("c_user_rst", c_user_rst, mdl_user_rst);
      end

      for (int i = 0; i < N_TX; i++) begin
         d = $random(seed);
         exp_tx.push_back(d[7:0]);
         bus_write(TX_DATA_ADDR, d);
         read_check(TX_BUSY_ADDR, "tx_busy in frame", 1'b1, 1);
         bus_write(TX_DATA_ADDR, ~d);   // Must be dropped
         wait_tx_frame(i + 1);
         wait_tx_idle();
      end

      repeat (4) begin
         a = $random(seed);
         while (a == TX_BUSY_ADDR || a == RX_REC_ADDR || a == RX_FULL_ADDR) a = $random(seed);
         read_check(a, "unmapped read", 1'b0, 0);
      end
      read_check(TX_DATA_ADDR, "tx data read", 1'b0, 0);
      bus_read(TX_BUSY_ADDR, rd_ready, rd_data);
      check("bus_rd_ready tx_busy", rd_ready, 1'b1);
      bus_read(RX_REC_ADDR, rd_ready, rd_data);
      check("bus_rd_ready rx_rec", rd_ready, 1'b1);
      bus_read(RX_FULL_ADDR, rd_ready, rd_data);
      check("bus_rd_ready rx_full", rd_ready, 1'b1);

      send_byte(CMD_COM_MODE);
      for (int i = 0; i < N_COM; i++) begin
         send_byte(byte_t'($random(seed)));
         read_check(RX_FULL_ADDR, "rx_full", 1'b1, mdl_rx_full);
         read_check(RX_REC_ADDR, "rx_rec", 1'b1, mdl_rx_rec);
         mdl_rx_full = 1'b0;   // Cleared by the receive register read
         read_check(RX_FULL_ADDR, "rx_full after read", 1'b1, mdl_rx_full);
      end
      // Full write command that must stay plain data
      send_byte(CMD_RST_CLR);
      check("c_user_rst", c_user_rst, mdl_user_rst);
      send_byte(CMD_PROG_MEM);
      repeat (6) send_byte(byte_t'($random(seed)));
      check("c_user_rst", c_user_rst, mdl_user_rst);
      read_check(RX_REC_ADDR, "rx_rec", 1'b1, mdl_rx_rec);

      if (exp_mem_addr.size() == 0 && exp_tx.size() == 0) begin
         $display("Result: PASSED");
         $finish;
      end else begin
         $display("Expected memory writes or transmit frames never appeared");
         end_with_failure();
      end
   end

endmodule

`default_nettype wire

/* hdl/uart_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_bridge (
   input  wire                      clk,
   input  wire                      c_ex_rst,
   input  wire                      uart_rx,
   output logic                     uart_tx,
   output logic                     c_user_rst,
   input  wire                      bus_wr_valid,
   input  wire uart_pkg::bus_addr_t bus_wr_addr,
   input  wire uart_pkg::bus_data_t bus_wr_data,
   input  wire                      bus_rd_valid,
   input  wire uart_pkg::bus_addr_t bus_rd_addr,
   output logic                     bus_rd_ready,
   output uart_pkg::bus_data_t      bus_rd_data,
   output logic                     mem_wr_valid,
   output uart_pkg::bus_addr_t      mem_wr_addr,
   output uart_pkg::bus_data_t      mem_wr_data
);
   import uart_pkg::*;

   logic  rx_valid;
   byte_t rx_data;
   logic  com_valid;
   logic  tx_start;
   byte_t tx_byte;
   logic  tx_busy;

   uart_rx u_rx (
      .clk      (clk),
      .c_ex_rst (c_ex_rst),
      .uart_rx  (uart_rx),
      .rx_valid (rx_valid),
      .rx_data  (rx_data)
   );

   cmd_decoder u_cmd (
      .clk          (clk),
      .c_ex_rst     (c_ex_rst),
      .rx_valid     (rx_valid),
      .rx_data      (rx_data),
      .mem_wr_valid (mem_wr_valid),
      .mem_wr_addr  (mem_wr_addr),
      .mem_wr_data  (mem_wr_data),
      .c_user_rst   (c_user_rst),
      .com_valid    (com_valid)
   );

   bus_regs u_regs (
      .clk          (clk),
      .c_ex_rst     (c_ex_rst),
      .bus_wr_valid (bus_wr_valid),
      .bus_wr_addr  (bus_wr_addr),
      .bus_wr_data  (bus_wr_data),
      .bus_rd_valid (bus_rd_valid),
      .bus_rd_addr  (bus_rd_addr),
      .bus_rd_ready (bus_rd_ready),
      .bus_rd_data  (bus_rd_data),
      .rx_data      (rx_data),
      .com_valid    (com_valid),
      .tx_busy      (tx_busy),
      .tx_start     (tx_start),
      .tx_byte      (tx_byte)
   );

   uart_tx u_tx (
      .clk      (clk),
      .c_ex_rst (c_ex_rst),
      .tx_start (tx_start),
      .tx_byte  (tx_byte),
      .uart_tx  (uart_tx),
      .tx_busy  (tx_busy)
   );

endmodule

`default_nettype wire

/* hdl/bus_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_regs (
   input  wire                      clk,
   input  wire                      c_ex_rst,
   input  wire                      bus_wr_valid,
   input  wire uart_pkg::bus_addr_t bus_wr_addr,
   input  wire uart_pkg::bus_data_t bus_wr_data,
   input  wire                      bus_rd_valid,
   input  wire uart_pkg::bus_addr_t bus_rd_addr,
   output logic                     bus_rd_ready,
   output uart_pkg::bus_data_t      bus_rd_data,
   input  wire uart_pkg::byte_t     rx_data,
   input  wire                      com_valid,
   input  wire                      tx_busy,
   output logic                     tx_start,
   output uart_pkg::byte_t          tx_byte
);
   import uart_pkg::*;

   byte_t rx_rec;
   logic  rx_full;
   logic  rd_tx_busy;
   logic  rd_rx_rec;
   logic  rd_rx_full;

   assign tx_start = bus_wr_valid && (bus_wr_addr == TX_DATA_ADDR);
   assign tx_byte  = bus_wr_data[7:0];

   assign rd_tx_busy = bus_rd_valid && (bus_rd_addr == TX_BUSY_ADDR);
   assign rd_rx_rec  = bus_rd_valid && (bus_rd_addr == RX_REC_ADDR);
   assign rd_rx_full = bus_rd_valid && (bus_rd_addr == RX_FULL_ADDR);

   // Overwritten by each byte, no back-pressure
   always_ff @(posedge clk) begin
      if (com_valid) begin
         rx_rec <= rx_data;
      end
   end

   always_ff @(posedge clk or posedge c_ex_rst) begin
      if (c_ex_rst) begin
         rx_full <= 1'b0;
      end else if (com_valid) begin
         rx_full <= 1'b1;   // New byte wins over a read
      end else if (rd_rx_rec) begin
         rx_full <= 1'b0;
      end
   end

   always_comb begin
      bus_rd_data = '0;
      if (rd_tx_busy) begin
         bus_rd_data = bus_data_t'(tx_busy);
      end else if (rd_rx_rec) begin
         bus_rd_data = bus_data_t'(rx_rec);
      end else if (rd_rx_full) begin
         bus_rd_data = bus_data_t'(rx_full);
      end
   end

   assign bus_rd_ready = rd_tx_busy || rd_rx_rec || rd_rx_full;

   assert property (@(posedge clk) disable iff (c_ex_rst) bus_rd_ready |-> bus_rd_valid)
      else $error("bus_rd_ready without bus_rd_valid");

endmodule

`default_nettype wire

/* hdl/cmd_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder (
   input  wire                  clk,
   input  wire                  c_ex_rst,
   input  wire                  rx_valid,
   input  wire uart_pkg::byte_t rx_data,
   output logic                 mem_wr_valid,
   output uart_pkg::bus_addr_t  mem_wr_addr,
   output uart_pkg::bus_data_t  mem_wr_data,
   output logic                 c_user_rst,
   output logic                 com_valid
);
   import uart_pkg::*;

   cmd_state_t state;
   mem_addr_t  wr_addr;
   bus_data_t  wr_data;

   always_ff @(posedge clk or posedge c_ex_rst) begin
      if (c_ex_rst) begin
         state        <= CMD_EXEC;
         c_user_rst   <= 1'b1;
         mem_wr_valid <= 1'b0;
      end else begin
         mem_wr_valid <= 1'b0;
         if (rx_valid) begin
            unique case (state)
               CMD_EXEC: begin
                  if (rx_data == CMD_PROG_MEM) begin
                     state <= CMD_ADDR_B0;
                  end else if (rx_data == CMD_RST_CLR) begin
                     c_user_rst <= 1'b0;
                  end else if (rx_data == CMD_RST_SET) begin
                     c_user_rst <= 1'b1;
                  end else if (rx_data == CMD_COM_MODE) begin
                     state <= CMD_COM;
                  end
               end
               CMD_ADDR_B0: state <= CMD_ADDR_B1;
               CMD_ADDR_B1: state <= CMD_DAT_B0;
               CMD_DAT_B0:  state <= CMD_DAT_B1;
               CMD_DAT_B1:  state <= CMD_DAT_B2;
               CMD_DAT_B2:  state <= CMD_DAT_B3;
               CMD_DAT_B3: begin
                  state        <= CMD_EXEC;
                  mem_wr_valid <= 1'b1;   // Last data byte lands on the same edge
               end
               CMD_COM: state <= CMD_COM;
            endcase
         end
      end
   end

   // Address and data bytes, LSB first
   always_ff @(posedge clk) begin
      if (rx_valid) begin
         unique case (state)
            CMD_ADDR_B0: wr_addr[7:0]   <= rx_data;
            CMD_ADDR_B1: wr_addr[15:8]  <= rx_data;
            CMD_DAT_B0:  wr_data[7:0]   <= rx_data;
            CMD_DAT_B1:  wr_data[15:8]  <= rx_data;
            CMD_DAT_B2:  wr_data[23:16] <= rx_data;
            CMD_DAT_B3:  wr_data[31:24] <= rx_data;
            default: begin
            end
         endcase
      end
   end

   assign mem_wr_addr = bus_addr_t'(wr_addr);
   assign mem_wr_data = wr_data;

   // Every byte goes to the bus side once in com mode
   assign com_valid = rx_valid && (state == CMD_COM);

   assert property (@(posedge clk) disable iff (c_ex_rst) mem_wr_valid |=> !mem_wr_valid)
      else $error("mem_wr_valid high on two consecutive cycles");

endmodule

`default_nettype wire

/* tx/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
   input  wire                  clk,
   input  wire                  c_ex_rst,
   input  wire                  tx_start,
   input  wire uart_pkg::byte_t tx_byte,
   output logic                 uart_tx,
   output logic                 tx_busy
);
   import uart_pkg::*;

   tx_state_t  state;
   baud_cnt_t  baud_cnt;
   logic [2:0] bit_cnt;    // Data bits already sent
   byte_t      shreg;
   logic       bit_tick;

   assign bit_tick = (baud_cnt == BIT_LAST);
   assign tx_busy  = (state != TX_IDLE);

   always_ff @(posedge clk or posedge c_ex_rst) begin
      if (c_ex_rst) begin
         state    <= TX_IDLE;
         baud_cnt <= '0;
         bit_cnt  <= '0;
         uart_tx  <= 1'b1;
      end else begin
         unique case (state)
            TX_IDLE: begin
               if (tx_start) begin
                  state    <= TX_START;
                  baud_cnt <= '0;
                  bit_cnt  <= '0;
                  uart_tx  <= 1'b0;   // Start bit
               end
            end
            TX_START: begin
               baud_cnt <= baud_cnt + 1'b1;
               if (bit_tick) begin
                  baud_cnt <= '0;
                  uart_tx  <= shreg[0];
                  state    <= TX_SHIFT;
               end
            end
            TX_SHIFT: begin
               baud_cnt <= baud_cnt + 1'b1;
               if (bit_tick) begin
                  baud_cnt <= '0;
                  bit_cnt  <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7) begin
                     uart_tx <= 1'b1;   // Stop bit
                     state   <= TX_STOP;
                  end else begin
                     uart_tx <= shreg[0];
                  end
               end
            end
            TX_STOP: begin
               baud_cnt <= baud_cnt + 1'b1;
               if (bit_tick) begin
                  state <= TX_IDLE;
               end
            end
         endcase
      end
   end

   // Frame data, loaded only when idle
   always_ff @(posedge clk) begin
      if (state == TX_IDLE && tx_start) begin
         shreg <= tx_byte;
      end else if ((state == TX_START || state == TX_SHIFT) && bit_tick) begin
         shreg <= {1'b0, shreg[7:1]};
      end
   end

   assert property (@(posedge clk) disable iff (c_ex_rst) (state == TX_IDLE) |-> uart_tx)
      else $error("uart_tx low while transmitter idle");

endmodule

`default_nettype wire

/* rx/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
   input  wire                  clk,
   input  wire                  c_ex_rst,
   input  wire                  uart_rx,
   output logic                 rx_valid,
   output uart_pkg::byte_t      rx_data
);
   import uart_pkg::*;

   logic [2:0] nrx_filt;   // Inverted line, newest in bit 0
   logic       maj_low;
   rx_state_t  state;
   baud_cnt_t  baud_cnt;
   logic [8:0] shreg;      // Data plus sentinel
   logic       bit_tick;
   logic       half_tick;

   assign bit_tick  = (baud_cnt == BIT_LAST);
   assign half_tick = (baud_cnt == HALF_LAST);

   // Line filter and majority decision
   always_ff @(posedge clk or posedge c_ex_rst) begin
      if (c_ex_rst) begin
         nrx_filt <= '0;
         maj_low  <= 1'b0;
      end else begin
         nrx_filt <= {nrx_filt[1:0], ~uart_rx};
         maj_low  <= (nrx_filt[0] & nrx_filt[1]) |
                     (nrx_filt[0] & nrx_filt[2]) |
                     (nrx_filt[1] & nrx_filt[2]);
      end
   end

   always_ff @(posedge clk or posedge c_ex_rst) begin
      if (c_ex_rst) begin
         state    <= RX_WAIT;
         baud_cnt <= '0;
      end else begin
         baud_cnt <= baud_cnt + 1'b1;
         unique case (state)
            RX_WAIT: begin
               baud_cnt <= '0;
               if (nrx_filt == 3'b111) begin   // Three low samples
                  state <= RX_START;
               end
            end
            RX_START: begin
               if (half_tick) begin
                  baud_cnt <= '0;
                  state    <= RX_SHIFT;
               end
            end
            RX_SHIFT: begin
               if (bit_tick) begin
                  baud_cnt <= '0;
               end
               // Sentinel reached bit 0, all 8 bits in
               if (shreg[0]) begin
                  state <= RX_STOP;
               end
            end
            RX_STOP: begin
               if (bit_tick) begin
                  state <= RX_WAIT;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == RX_WAIT) begin
         shreg <= 9'h100;
      end else if (state == RX_SHIFT && bit_tick) begin
         shreg <= {~maj_low, shreg[8:1]};   // LSB first
      end
   end

   assign rx_valid = (state == RX_STOP) && bit_tick;
   assign rx_data  = shreg[8:1];

   assert property (@(posedge clk) disable iff (c_ex_rst) rx_valid |=> !rx_valid)
      else $error("rx_valid high on two consecutive cycles");

endmodule

`default_nettype wire

/* common/uart_pkg.sv */
`default_nettype none

package uart_pkg;

   typedef logic [7:0]  byte_t;
   typedef logic [31:0] bus_addr_t;
   typedef logic [31:0] bus_data_t;
   typedef logic [15:0] mem_addr_t;
   typedef logic [8:0]  baud_cnt_t;

   // Bit timing in clock cycles
   localparam int CLKS_PER_BIT  = 478;
   localparam int CLKS_HALF_BIT = 240;
   localparam baud_cnt_t BIT_LAST  = baud_cnt_t'(CLKS_PER_BIT - 1);
   localparam baud_cnt_t HALF_LAST = baud_cnt_t'(CLKS_HALF_BIT - 1);

   // Slave register map
   localparam bus_addr_t TX_DATA_ADDR = 32'h8002_0000;
   localparam bus_addr_t TX_BUSY_ADDR = 32'h8002_0010;
   localparam bus_addr_t RX_REC_ADDR  = 32'h8002_0020;
   localparam bus_addr_t RX_FULL_ADDR = 32'h8002_0030;

   localparam byte_t CMD_PROG_MEM = 8'h30;   // Followed by 2 addr and 4 data bytes
   localparam byte_t CMD_RST_CLR  = 8'h10;
   localparam byte_t CMD_RST_SET  = 8'h11;
   localparam byte_t CMD_COM_MODE = 8'h50;   // No way back out

   typedef enum logic [1:0] {
      RX_WAIT,
      RX_START,
      RX_SHIFT,
      RX_STOP
   } rx_state_t;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_SHIFT,
      TX_STOP
   } tx_state_t;

   typedef enum logic [2:0] {
      CMD_EXEC,
      CMD_ADDR_B0,
      CMD_ADDR_B1,
      CMD_DAT_B0,
      CMD_DAT_B1,
      CMD_DAT_B2,
      CMD_DAT_B3,
      CMD_COM
   } cmd_state_t;

endpackage

`default_nettype wire
